// File: Bender.yml
package:
  name: core_mem

sources:
  - core_mem_pkg.sv
  - mem_stall_gen.sv
  - core_ram.sv
  - core_mem.sv
  - rtc_timer.sv
  - core_mem_top.sv
  - target: test
    files:
      - tb_core_mem.sv

// File: all.f
core_mem_pkg.sv
mem_stall_gen.sv
core_ram.sv
core_mem.sv
rtc_timer.sv
core_mem_top.sv
tb_core_mem.sv

// File: core_mem.sv
// ====================================================================
// memory controller for the fetch and data ports of the core
// arbitration, two-phase data address with kill, shared ram access
// and routing of the ram output to the matching response
// ====================================================================

`timescale 1ns/1ps

module core_mem #(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    // instruction fetch port
    input  logic                     instr_req_i,
    input  core_mem_pkg::instr_req_t instr_i,
    output logic                     instr_gnt_o,
    output core_mem_pkg::mem_rsp_t   instr_rsp_o,
    // data port, index with the request and tag one cycle later
    input  logic                     data_req_i,
    input  core_mem_pkg::data_req_t  data_i,
    input  core_mem_pkg::data_tag_t  data_tag_i,
    output logic                     data_gnt_o,
    output core_mem_pkg::mem_rsp_t   data_rsp_o
);

    localparam int unsigned AW    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int unsigned PAD_W = core_mem_pkg::ADDR_W - core_mem_pkg::TAG_W
                                    - core_mem_pkg::INDEX_W;
    localparam int unsigned WSH   = $clog2(core_mem_pkg::BE_W);

    // first phase of the granted data access, used in the tag cycle
    core_mem_pkg::data_req_t data_q;
    logic                    tag_pend_q;
    logic                    data_access;
    logic                    instr_rvalid_q;
    logic                    data_rvalid_q;

    logic [core_mem_pkg::ADDR_W-1:0] data_byte_addr;

    // shared ram port
    logic                            ram_en;
    logic                            ram_we;
    logic [AW-1:0]                   ram_addr;
    logic [core_mem_pkg::DATA_W-1:0] ram_rdata;

    // byte address to ram word, wrapping over the ram depth
    function automatic logic [AW-1:0] word_addr(
        input logic [core_mem_pkg::ADDR_W-1:0] byte_addr
    );
        logic [core_mem_pkg::ADDR_W-1:0] offset;
        offset = (byte_addr - core_mem_pkg::DRAM_BASE) >> WSH;
        return offset[AW-1:0];
    endfunction

    // data wins over fetch, data uses the ram only in its tag cycle
    // so it can be granted back to back
    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i & ~data_req_i & ~tag_pend_q;

    // kill overrides tag_valid
    assign data_access = tag_pend_q & data_tag_i.tag_valid & ~data_tag_i.kill;

    assign data_byte_addr = {{PAD_W{1'b0}}, data_tag_i.tag, data_q.index};

    // fetch can never be granted in a tag cycle, so tag_pend_q selects
    assign ram_en   = instr_gnt_o | data_access;
    assign ram_we   = data_access & data_q.we;
    assign ram_addr = tag_pend_q ? word_addr(data_byte_addr) : word_addr(instr_i.addr);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tag_pend_q     <= 1'b0;
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            tag_pend_q     <= data_gnt_o;
            instr_rvalid_q <= instr_gnt_o;
            data_rvalid_q  <= data_access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_gnt_o) begin
            data_q <= data_i;
        end
    end

    core_ram #(
        .MEM_WORDS ( MEM_WORDS      )
    ) ram_i (
        .clk_i     ( clk_i          ),
        .en_i      ( ram_en         ),
        .we_i      ( ram_we         ),
        .be_i      ( data_q.be      ),
        .addr_i    ( ram_addr       ),
        .wdata_i   ( data_q.wdata   ),
        .rdata_o   ( ram_rdata      )
    );

    // fetch answers one cycle after grant, data two
    assign instr_rsp_o = '{rvalid: instr_rvalid_q, rdata: ram_rdata};
    assign data_rsp_o  = '{rvalid: data_rvalid_q,  rdata: ram_rdata};

    // tag phase only in the cycle right after a data grant
    a_tag_after_gnt: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (data_tag_i.tag_valid || data_tag_i.kill) |-> $past(data_gnt_o)
    ) else $error("tag_valid or kill outside a tag cycle");

    // and that cycle must carry either tag_valid or kill
    a_tag_present: assert property (
        @(posedge clk_i) disable iff (rst_i)
        data_gnt_o |=> (data_tag_i.tag_valid || data_tag_i.kill)
    ) else $error("data grant not followed by tag_valid or kill");

    // one ram access per cycle
    a_gnt_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        instr_gnt_o |-> !data_gnt_o && !$past(data_gnt_o)
    ) else $error("fetch granted against a data grant or tag cycle");

endmodule

// File: core_mem_pkg.sv
// ====================================================================
// shared widths and memory base address of the core memory harness
// packed structs for the fetch request, the two-phase data request
// and the response of either port
// ====================================================================

package core_mem_pkg;

    // port widths
    localparam int unsigned ADDR_W  = 64;
    localparam int unsigned DATA_W  = 64;
    localparam int unsigned BE_W    = DATA_W / 8;
    localparam int unsigned INDEX_W = 12;
    localparam int unsigned TAG_W   = 44;

    // byte address that maps onto ram word 0
    localparam logic [ADDR_W-1:0] DRAM_BASE = 64'h0000_0000_8000_0000;

    // fetch request, address only
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } instr_req_t;

    // data request, first address phase with the payload
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [DATA_W-1:0]  wdata;
        logic               we;
        logic [BE_W-1:0]    be;
    } data_req_t;

    // second address phase, one cycle after the grant
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             tag_valid;
        logic             kill;
    } data_tag_t;

    // read response, the same for both ports
    typedef struct packed {
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: core_mem_top.sv
// ====================================================================
// top level of the core memory harness
// stall injectors on both ports, memory controller and timer
// ====================================================================

`timescale 1ns/1ps

module core_mem_top #(
    parameter int unsigned MEM_WORDS    = 1024,
    parameter int unsigned RTC_DIV      = 16,
    parameter logic [15:0] STALL_SEED_I = 16'hace1,
    parameter logic [15:0] STALL_SEED_D = 16'h5a3c
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     stall_en_i,
    // instruction fetch port
    input  logic                     instr_req_i,
    input  core_mem_pkg::instr_req_t instr_i,
    output logic                     instr_gnt_o,
    output core_mem_pkg::mem_rsp_t   instr_rsp_o,
    // data port
    input  logic                     data_req_i,
    input  core_mem_pkg::data_req_t  data_i,
    input  core_mem_pkg::data_tag_t  data_tag_i,
    output logic                     data_gnt_o,
    output core_mem_pkg::mem_rsp_t   data_rsp_o,
    // real time
    output logic [63:0]              time_o
);

    // requests after the stall injectors
    logic                     instr_req_m;
    core_mem_pkg::instr_req_t instr_m;
    logic                     instr_gnt_m;
    logic                     data_req_m;
    core_mem_pkg::data_req_t  data_m;
    logic                     data_gnt_m;

    mem_stall_gen #(
        .req_t      ( core_mem_pkg::instr_req_t ),
        .SEED       ( STALL_SEED_I              )
    ) instr_stall_i (
        .clk_i      ( clk_i                     ),
        .rst_i      ( rst_i                     ),
        .stall_en_i ( stall_en_i                ),
        .core_req_i ( instr_req_i               ),
        .core_pay_i ( instr_i                   ),
        .core_gnt_o ( instr_gnt_o               ),
        .mem_req_o  ( instr_req_m               ),
        .mem_pay_o  ( instr_m                   ),
        .mem_gnt_i  ( instr_gnt_m               )
    );

    mem_stall_gen #(
        .req_t      ( core_mem_pkg::data_req_t  ),
        .SEED       ( STALL_SEED_D              )
    ) data_stall_i (
        .clk_i      ( clk_i                     ),
        .rst_i      ( rst_i                     ),
        .stall_en_i ( stall_en_i                ),
        .core_req_i ( data_req_i                ),
        .core_pay_i ( data_i                    ),
        .core_gnt_o ( data_gnt_o                ),
        .mem_req_o  ( data_req_m                ),
        .mem_pay_o  ( data_m                    ),
        .mem_gnt_i  ( data_gnt_m                )
    );

    core_mem #(
        .MEM_WORDS   ( MEM_WORDS   )
    ) core_mem_i (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .instr_req_i ( instr_req_m ),
        .instr_i     ( instr_m     ),
        .instr_gnt_o ( instr_gnt_m ),
        .instr_rsp_o ( instr_rsp_o ),
        .data_req_i  ( data_req_m  ),
        .data_i      ( data_m      ),
        .data_tag_i  ( data_tag_i  ),
        .data_gnt_o  ( data_gnt_m  ),
        .data_rsp_o  ( data_rsp_o  )
    );

    rtc_timer #(
        .RTC_DIV ( RTC_DIV )
    ) rtc_timer_i (
        .clk_i   ( clk_i   ),
        .rst_i   ( rst_i   ),
        .time_o  ( time_o  )
    );

endmodule

// File: core_ram.sv
// ====================================================================
// single-port double-word ram
// byte-masked writes and a registered read of the old contents
// ====================================================================

`timescale 1ns/1ps

module core_ram #(
    parameter  int unsigned MEM_WORDS = 1024,
    localparam int unsigned AW        = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
    input  logic                            clk_i,
    input  logic                            en_i,
    input  logic                            we_i,
    input  logic [core_mem_pkg::BE_W-1:0]   be_i,
    input  logic [AW-1:0]                   addr_i,
    input  logic [core_mem_pkg::DATA_W-1:0] wdata_i,
    output logic [core_mem_pkg::DATA_W-1:0] rdata_o
);

    logic [core_mem_pkg::DATA_W-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                // only enabled bytes change
                for (int b = 0; b < core_mem_pkg::BE_W; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            // read first, a write returns the previous word
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// File: mem_stall_gen.sv
// ====================================================================
// grant stall injector between a core port and the memory
// a 16-bit LFSR hides the request in random cycles while enabled
// ====================================================================

`timescale 1ns/1ps

module mem_stall_gen #(
    parameter type         req_t = logic,
    parameter logic [15:0] SEED  = 16'hace1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic stall_en_i,
    // core side
    input  logic core_req_i,
    input  req_t core_pay_i,
    output logic core_gnt_o,
    // memory side
    output logic mem_req_o,
    output req_t mem_pay_o,
    input  logic mem_gnt_i
);

    logic [15:0] lfsr_q;
    logic        lfsr_fb;
    logic        stall;

    // taps 16, 14, 13 and 11 give the maximal length sequence
    assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // free running, also while stalls are switched off
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfsr_q <= SEED;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_fb};
        end
    end

    assign stall = stall_en_i & lfsr_q[0];

    // memory never sees a stalled request, so it cannot grant it
    assign mem_req_o  = core_req_i & ~stall;
    assign mem_pay_o  = core_pay_i;
    assign core_gnt_o = mem_gnt_i & ~stall;

    // all-zero state would lock up the LFSR and silently disable stalls
    a_lfsr_alive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        lfsr_q != 16'h0000
    ) else $error("stall LFSR stuck at zero, check SEED");

    // a grant reaching the core must belong to a live request
    a_gnt_has_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        core_gnt_o |-> core_req_i
    ) else $error("grant without request");

    // core holds its request and payload until the grant
    a_req_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        core_req_i && !core_gnt_o |=> core_req_i && $stable(core_pay_i)
    ) else $error("request dropped or changed before grant");

endmodule

// File: rtc_timer.sv
// ====================================================================
// real-time counter, 64-bit time value behind a clock prescaler
// ====================================================================

`timescale 1ns/1ps

module rtc_timer #(
    parameter int unsigned RTC_DIV = 16
) (
    input  logic        clk_i,
    input  logic        rst_i,
    output logic [63:0] time_o
);

    localparam int unsigned PW = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

    logic [PW-1:0] presc_q;
    logic          tick;

    // last prescaler count, time advances here
    assign tick = (presc_q == PW'(RTC_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            presc_q <= '0;
            time_o  <= '0;
        end else if (tick) begin
            presc_q <= '0;
            time_o  <= time_o + 64'd1;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    a_div_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        RTC_DIV >= 1
    ) else $error("RTC_DIV must be at least 1");

endmodule

// File: tb_core_mem.sv
// ======================================================================
// testbench for the core memory harness
// fetch and data port drivers, byte-wise reference memory model,
// assertions on grants, response timing and read data, watchdog
// ======================================================================

`timescale 1ns/1ps

module tb_core_mem;

    localparam int unsigned MEM_WORDS  = 1024;
    localparam int unsigned RTC_DIV    = 16;
    localparam int          CLK_PERIOD = 40;
    localparam int          QUARTER    = CLK_PERIOD / 4;
    localparam int unsigned MAX_WAIT   = 256;
    localparam int unsigned N_RW       = 24;
    localparam int unsigned N_FETCH    = 16;
    localparam int unsigned N_KILL     = 8;
    localparam int unsigned N_MIX      = 48;
    localparam int unsigned N_TICKS    = 4;
    // small window so that mixed reads hit words written before
    localparam int unsigned MIX_SPAN   = 8;

    // nominal cycles of all tests together
    localparam int unsigned TEST_CYCLES = 8 + N_RW * 3 * 2 + N_FETCH * 2 + N_KILL * 4 * 2
                                          + N_MIX * 4 + RTC_DIV * (N_TICKS + 2);
    localparam int unsigned WATCHDOG_CYCLES = TEST_CYCLES * 4 + 500;

    // expected read data, travels along with the response latency
    typedef struct packed {
        logic        chk;
        logic [63:0] data;
    } exp_t;

    logic                     clk;
    logic                     rst;
    logic                     stall_en;
    logic                     instr_req;
    core_mem_pkg::instr_req_t instr_pay;
    logic                     instr_gnt;
    core_mem_pkg::mem_rsp_t   instr_rsp;
    logic                     data_req;
    core_mem_pkg::data_req_t  data_pay;
    core_mem_pkg::data_tag_t  data_tag;
    logic                     data_gnt;
    core_mem_pkg::mem_rsp_t   data_rsp;
    logic [63:0]              time_val;

    logic [7:0]               ref_mem [MEM_WORDS * 8];
    core_mem_pkg::data_tag_t  tag_next;
    exp_t                     i_exp_nxt;
    exp_t                     i_exp_p1;
    exp_t                     d_exp_nxt;
    exp_t                     d_exp_p1;
    exp_t                     d_exp_p2;
    int unsigned              rw_words [$];
    int unsigned              d_stall_cnt;
    int                       errors;
    int                       tests_run;
    int                       tests_failed;
    int                       test_err_start;
    string                    cur_test;
    integer                   seed;

    core_mem_top #(
        .MEM_WORDS   ( MEM_WORDS ),
        .RTC_DIV     ( RTC_DIV   )
    ) UUT (
        .clk_i       ( clk       ),
        .rst_i       ( rst       ),
        .stall_en_i  ( stall_en  ),
        .instr_req_i ( instr_req ),
        .instr_i     ( instr_pay ),
        .instr_gnt_o ( instr_gnt ),
        .instr_rsp_o ( instr_rsp ),
        .data_req_i  ( data_req  ),
        .data_i      ( data_pay  ),
        .data_tag_i  ( data_tag  ),
        .data_gnt_o  ( data_gnt  ),
        .data_rsp_o  ( data_rsp  ),
        .time_o      ( time_val  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        i_exp_p1 <= i_exp_nxt;
        d_exp_p1 <= d_exp_nxt;
        d_exp_p2 <= d_exp_p1;
    end

    a_instr_rvalid: assert property (@(posedge clk) disable iff (rst)
        instr_gnt |=> instr_rsp.rvalid)
    else begin
        errors++;
        $display("%s: fetch rvalid missing one cycle after grant at %0t", cur_test, $time);
    end

    a_instr_spurious: assert property (@(posedge clk) disable iff (rst)
        instr_rsp.rvalid |-> $past(instr_gnt))
    else begin
        errors++;
        $display("%s: fetch rvalid without a grant one cycle before", cur_test);
    end

    a_instr_rdata: assert property (@(posedge clk) disable iff (rst)
        instr_rsp.rvalid && i_exp_p1.chk |-> instr_rsp.rdata === i_exp_p1.data)
    else begin
        errors++;
        $display("Fail %s: fetch data expected %h, actual %h", cur_test,
                 $sampled(i_exp_p1.data), $sampled(instr_rsp.rdata));
    end

    // accepted tag phase gives rvalid two cycles after the grant
    a_data_rvalid: assert property (@(posedge clk) disable iff (rst)
        data_gnt ##1 (data_tag.tag_valid && !data_tag.kill) |=> data_rsp.rvalid)
    else begin
        errors++;
        $display("%s: data rvalid missing two cycles after grant", cur_test);
    end

    a_data_spurious: assert property (@(posedge clk) disable iff (rst)
        data_rsp.rvalid |-> $past(data_gnt, 2)
                            && $past(data_tag.tag_valid && !data_tag.kill))
    else begin
        errors++;
        $display("%s: data rvalid without an accepted access before it", cur_test);
    end

    a_data_rdata: assert property (@(posedge clk) disable iff (rst)
        data_rsp.rvalid && d_exp_p2.chk |-> data_rsp.rdata === d_exp_p2.data)
    else begin
        errors++;
        $display("Fail %s: data read expected %h, actual %h", cur_test,
                 $sampled(d_exp_p2.data), $sampled(data_rsp.rdata));
    end

    a_gnt_excl: assert property (@(posedge clk) disable iff (rst)
        instr_gnt |-> !data_gnt && !data_tag.tag_valid && !data_tag.kill)
    else begin
        errors++;
        $display("%s: fetch granted together with a data grant or tag cycle", cur_test);
    end

    a_time_step: assert property (@(posedge clk) disable iff (rst)
        time_val != $past(time_val) |-> time_val == $past(time_val) + 64'd1)
    else begin
        errors++;
        $display("%s: time value jumped by more than one", cur_test);
    end

    function automatic logic [63:0] byte_addr_of(input int unsigned word);
        return core_mem_pkg::DRAM_BASE + 64'(word) * 64'd8;
    endfunction

    function automatic logic [63:0] model_read(input int unsigned word);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = ref_mem[word * 8 + b];
        end
        return w;
    endfunction

    task automatic model_write(input int unsigned word, input logic [63:0] wdata,
                               input logic [7:0] be);
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                ref_mem[word * 8 + b] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic expect_equal(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: %s expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // starts and ends on a falling edge, the tag goes out with the next call
    task automatic data_op(input int unsigned word, input logic we, input logic [7:0] be,
                           input logic [63:0] wdata, input logic kill);
        logic [63:0] addr;
        int unsigned waited;
        addr = byte_addr_of(word);
        data_req = 1'b1;
        data_pay.index = addr[11:0];
        data_pay.wdata = wdata;
        data_pay.we = we;
        data_pay.be = be;
        data_tag = tag_next;
        tag_next = '0;
        d_exp_nxt = '0;
        waited = 0;
        #(QUARTER);
        while (!data_gnt && waited < MAX_WAIT) begin
            waited++;
            @(negedge clk);
            data_tag = '0;
            #(QUARTER);
        end
        d_stall_cnt += waited;
        if (!data_gnt) begin
            errors++;
            $display("%s: data request not granted within %0d cycles", cur_test, MAX_WAIT);
        end
        if (we && !kill) begin
            model_write(word, wdata, be);
        end
        d_exp_nxt.chk = !we && !kill;
        d_exp_nxt.data = model_read(word);
        tag_next.tag = addr[55:12];
        tag_next.tag_valid = !kill;
        tag_next.kill = kill;
        @(negedge clk);
    endtask

    task automatic data_idle();
        data_req = 1'b0;
        data_tag = tag_next;
        tag_next = '0;
        d_exp_nxt = '0;
        @(negedge clk);
        data_tag = '0;
        repeat (2) @(negedge clk);
    endtask

    task automatic fetch_op(input int unsigned word);
        int unsigned waited;
        instr_req = 1'b1;
        instr_pay.addr = byte_addr_of(word);
        i_exp_nxt = '0;
        waited = 0;
        #(QUARTER);
        while (!instr_gnt && waited < MAX_WAIT) begin
            waited++;
            @(negedge clk);
            #(QUARTER);
        end
        if (!instr_gnt) begin
            errors++;
            $display("%s: fetch request not granted within %0d cycles", cur_test, MAX_WAIT);
        end
        i_exp_nxt.chk = 1'b1;
        i_exp_nxt.data = model_read(word);
        @(negedge clk);
    endtask

    task automatic fetch_idle();
        instr_req = 1'b0;
        i_exp_nxt = '0;
        repeat (2) @(negedge clk);
    endtask

    task automatic test_reset();
        start_test("reset");
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(QUARTER);
        expect_equal("instr_gnt", 64'd0, 64'(instr_gnt));
        expect_equal("data_gnt", 64'd0, 64'(data_gnt));
        expect_equal("instr_rvalid", 64'd0, 64'(instr_rsp.rvalid));
        expect_equal("data_rvalid", 64'd0, 64'(data_rsp.rvalid));
        expect_equal("time", 64'd0, time_val);
        @(negedge clk);
        finish_test();
    endtask

    task automatic test_data_rw();
        int unsigned word;
        start_test("data_rw");
        for (int n = 0; n < N_RW; n++) begin
            word = $unsigned($random(seed)) % (MEM_WORDS / 2);
            rw_words.push_back(word);
            data_op(word, 1'b1, 8'hff, {$random(seed), $random(seed)}, 1'b0);
            data_op(word, 1'b1, 8'($random(seed)), {$random(seed), $random(seed)}, 1'b0);
            data_op(word, 1'b0, 8'h00, 64'd0, 1'b0);
        end
        data_idle();
        finish_test();
    endtask

    task automatic test_fetch();
        start_test("fetch");
        for (int n = 0; n < N_FETCH; n++) begin
            fetch_op(rw_words[n % rw_words.size()]);
        end
        fetch_idle();
        finish_test();
    endtask

    task automatic test_kill();
        int unsigned word;
        logic [63:0] wdata;
        start_test("kill");
        for (int n = 0; n < N_KILL; n++) begin
            word = $unsigned($random(seed)) % (MEM_WORDS / 2);
            wdata = {$random(seed), $random(seed)};
            data_op(word, 1'b1, 8'hff, wdata, 1'b0);
            data_op(word, 1'b1, 8'hff, ~wdata, 1'b1);
            data_op(word, 1'b0, 8'h00, 64'd0, 1'b1);
            data_op(word, 1'b0, 8'h00, 64'd0, 1'b0);
        end
        data_idle();
        finish_test();
    endtask

    // both ports busy, data in a small upper window and fetch from the lower half
    task automatic test_mixed();
        int unsigned mix_word [N_MIX];
        logic        mix_we [N_MIX];
        logic [7:0]  mix_be [N_MIX];
        logic [63:0] mix_wdata [N_MIX];
        int unsigned fetch_word [N_MIX / 2];
        start_test("mixed_stall");
        for (int n = 0; n < N_MIX; n++) begin
            mix_word[n] = MEM_WORDS / 2 + $unsigned($random(seed)) % MIX_SPAN;
            mix_we[n] = 1'($random(seed));
            mix_be[n] = 8'($random(seed));
            mix_wdata[n] = {$random(seed), $random(seed)};
        end
        for (int n = 0; n < N_MIX / 2; n++) begin
            fetch_word[n] = rw_words[$unsigned($random(seed)) % rw_words.size()];
        end
        stall_en = 1'b1;
        d_stall_cnt = 0;
        fork
            begin
                for (int n = 0; n < N_MIX; n++) begin
                    data_op(mix_word[n], mix_we[n], mix_be[n], mix_wdata[n], 1'b0);
                end
                data_idle();
            end
            begin
                for (int n = 0; n < N_MIX / 2; n++) begin
                    fetch_op(fetch_word[n]);
                end
                fetch_idle();
            end
        join
        stall_en = 1'b0;
        assert (d_stall_cnt > 0) else begin
            errors++;
            $display("%s: no grant was withheld while stalls were enabled", cur_test);
        end
        finish_test();
    endtask

    task automatic test_rtc();
        logic [63:0] t0;
        int unsigned waited;
        start_test("rtc");
        t0 = time_val;
        waited = 0;
        // line up with a tick first
        while (time_val == t0 && waited < 2 * RTC_DIV) begin
            @(negedge clk);
            waited++;
        end
        for (int k = 0; k < N_TICKS; k++) begin
            t0 = time_val;
            repeat (RTC_DIV - 1) @(negedge clk);
            expect_equal("time before tick", t0, time_val);
            @(negedge clk);
            expect_equal("time after tick", t0 + 64'd1, time_val);
        end
        finish_test();
    endtask

    initial begin
        seed = 70301;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        stall_en = 1'b0;
        instr_req = 1'b0;
        instr_pay = '0;
        data_req = 1'b0;
        data_pay = '0;
        data_tag = '0;
        tag_next = '0;
        i_exp_nxt = '0;
        d_exp_nxt = '0;
        test_reset();
        test_data_rw();
        test_fetch();
        test_kill();
        test_mixed();
        test_rtc();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
